/* hw/rhPkg.sv */
// Controller register layouts, write-data union, register select, offsets, function codes
`default_nettype none

package rhPkg;

   // CS1 layout, function and status
   typedef struct packed {
      logic       sc;
      logic       tre;
      logic [5:0] unused;
      logic       rdy;
      logic       ie;
      logic [4:0] func;
      logic       go;
   } rhCs1T;

   // CS2 layout, error flags in the high byte and unit control in the low byte
   typedef struct packed {
      logic       dlt;
      logic       wce;
      logic       upe;
      logic       ned;
      logic       nem;
      logic       pge;
      logic       mxf;
      logic       dpe;
      logic       orr;
      logic       irr;
      logic       clr;
      logic       pat;
      logic       bai;
      logic [2:0] unit;
   } rhCs2T;

   // One write word, seen as CS1 or CS2 or plain bits
   typedef union packed {
      rhCs1T       cs1;
      rhCs2T       cs2;
      logic [15:0] raw;
   } rhWordT;

   typedef enum logic [1:0] {
      regCs1 = 2'd0,
      regWc  = 2'd1,
      regBa  = 2'd2,
      regCs2 = 2'd3
   } rhRegT;

   // Byte offsets on the host bus
   localparam logic [3:0] offCs1 = 4'h0;
   localparam logic [3:0] offWc  = 4'h4;
   localparam logic [3:0] offBa  = 4'h8;
   localparam logic [3:0] offCs2 = 4'hC;

   // Data transfer functions, everything else is a no-op
   localparam logic [4:0] funcWrite = 5'o30;
   localparam logic [4:0] funcRead  = 5'o34;

endpackage

`default_nettype wire

/* hw/axiPkg.sv */
// AXI4-Lite request and response channel structs, response codes, decoded register write
`default_nettype none

package axiPkg;

   // Host to slave signals, all five channels
   typedef struct packed {
      // Write address
      logic [3:0]  awaddr;
      logic        awvalid;
      // Write data
      logic [31:0] wdata;
      logic [3:0]  wstrb;
      logic        wvalid;
      // Write response
      logic        bready;
      // Read address
      logic [3:0]  araddr;
      logic        arvalid;
      // Read data
      logic        rready;
   } axiReqT;

   // Slave to host signals
   typedef struct packed {
      logic        awready;
      logic        wready;
      logic        bvalid;
      logic [1:0]  bresp;
      logic        arready;
      logic [31:0] rdata;
      logic [1:0]  rresp;
      logic        rvalid;
   } axiRspT;

   // Every access completes normally
   localparam logic [1:0] respOkay = 2'b00;

   // One accepted register write, already split into byte lanes
   typedef struct packed {
      logic          valid;
      rhPkg::rhRegT  regSel;
      logic          loByte;
      logic          hiByte;
      rhPkg::rhWordT data;
   } regWriteT;

endpackage

`default_nettype wire

/* hw/axiRegPort.sv */
// AXI4-Lite slave port: write decode into register strobes, read response path
`timescale 1ns/1ps
`default_nettype none

module axiRegPort
(
   input  wire logic             clk,
   input  wire logic             rst,
   input  wire axiPkg::axiReqT   req,
   output axiPkg::axiRspT        rsp,
   output axiPkg::regWriteT      regWrite,
   input  wire logic [15:0]      cs1,
   input  wire logic [15:0]      cs2,
   input  wire logic [15:0]      wc,
   input  wire logic [15:0]      ba
);

   import rhPkg::*;
   import axiPkg::*;

   logic        bValid;
   logic        rValid;
   logic [15:0] rData;
   logic        wrAccept;
   logic        rdAccept;
   rhRegT       rdSel;

   // Byte offset to register, low address bits ignored
   function automatic rhRegT addrToReg(input logic [3:0] addr);
      rhRegT sel;
      case (addr & 4'hC)
         offCs1:  sel = regCs1;
         offWc:   sel = regWc;
         offBa:   sel = regBa;
         offCs2:  sel = regCs2;
         default: sel = regCs1;
      endcase
      return sel;
   endfunction

   //////////////////////////////////////////////////
   // Write channel
   //////////////////////////////////////////////////

   // Address and data taken together, only with no response waiting
   assign wrAccept = req.awvalid & req.wvalid & ~bValid;

   always_ff @(posedge clk)
   begin
      if (rst)
         bValid <= 1'b0;
      else if (wrAccept)
         bValid <= 1'b1;
      else if (req.bready)
         bValid <= 1'b0;
   end

   // Register strobe in the acceptance cycle
   always_comb
   begin
      regWrite.valid    = wrAccept;
      regWrite.regSel   = addrToReg(req.awaddr);
      regWrite.loByte   = req.wstrb[0];
      regWrite.hiByte   = req.wstrb[1];
      // Upper half of the bus carries nothing for 16-bit registers
      regWrite.data.raw = req.wdata[15:0];
   end

   //////////////////////////////////////////////////
   // Read channel
   //////////////////////////////////////////////////

   assign rdAccept = req.arvalid & ~rValid;
   assign rdSel    = addrToReg(req.araddr);

   always_ff @(posedge clk)
   begin
      if (rst)
         rValid <= 1'b0;
      else if (rdAccept)
         rValid <= 1'b1;
      else if (req.rready)
         rValid <= 1'b0;
   end

   // Snapshot of the register at acceptance, no reset needed
   always_ff @(posedge clk)
   begin
      if (rdAccept)
      begin
         case (rdSel)
            regCs1:  rData <= cs1;
            regWc:   rData <= wc;
            regBa:   rData <= ba;
            default: rData <= cs2;
         endcase
      end
   end

   // Response bundle
   always_comb
   begin
      rsp.awready = wrAccept;
      rsp.wready  = wrAccept;
      rsp.bvalid  = bValid;
      rsp.bresp   = respOkay;
      rsp.arready = ~rValid;
      rsp.rdata   = {16'h0000, rData};
      rsp.rresp   = respOkay;
      rsp.rvalid  = rValid;
   end

endmodule

`default_nettype wire

/* hw/rhCs1.sv */
// CS1 register: GO decode, ready, interrupt enable, function, error summary, interrupt pulse
`timescale 1ns/1ps
`default_nettype none

module rhCs1
(
   input  wire logic             clk,
   input  wire logic             rst,
   input  wire axiPkg::regWriteT regWrite,
   input  wire logic             busy,
   input  wire logic             done,
   input  wire logic             errSum,
   output rhPkg::rhCs1T          cs1,
   output logic                  startXfer,
   output logic                  goClr,
   output logic                  treClr,
   output logic                  setPge,
   output logic                  irq
);

   import rhPkg::*;

   logic       rdy;
   logic       ie;
   logic [4:0] func;
   logic       wrLo;
   logic       wrHi;
   logic       goWrite;
   logic       isXfer;
   rhCs1T      wd;

   // Write decode
   assign wd      = regWrite.data.cs1;
   assign wrLo    = regWrite.valid & (regWrite.regSel == regCs1) & regWrite.loByte;
   assign wrHi    = regWrite.valid & (regWrite.regSel == regCs1) & regWrite.hiByte;
   assign goWrite = wrLo & wd.go;
   assign isXfer  = (wd.func == funcRead) | (wd.func == funcWrite);

   // GO with a transfer function while idle
   assign startXfer = goWrite & rdy & isXfer;
   // Errors drop when a transfer starts
   assign goClr     = startXfer;
   // GO while busy is a program error, whatever the function
   assign setPge    = goWrite & ~rdy;
   assign treClr    = wrHi & wd.tre;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         rdy  <= 1'b1;
         ie   <= 1'b0;
         func <= '0;
         irq  <= 1'b0;
      end
      else
      begin
         // Ready falls at the GO edge, rises after done
         if (startXfer)
            rdy <= 1'b0;
         else if (done)
            rdy <= 1'b1;
         if (wrLo)
            ie <= wd.ie;
         // Function frozen during a transfer
         if (wrLo & rdy)
            func <= wd.func;
         // One-cycle interrupt at end of transfer
         irq <= done & ie;
      end
   end

   // Read view, GO shows the engine running
   always_comb
   begin
      cs1        = '0;
      cs1.sc     = errSum;
      cs1.tre    = errSum;
      cs1.rdy    = rdy;
      cs1.ie     = ie;
      cs1.func   = func;
      cs1.go     = busy;
   end

endmodule

`default_nettype wire

/* hw/rhCs2.sv */
// CS2 register: error flags with clear precedence, unit select, bai, parity test, controller clear
`timescale 1ns/1ps
`default_nettype none

module rhCs2
(
   input  wire logic             clk,
   input  wire logic             rst,
   input  wire axiPkg::regWriteT regWrite,
   input  wire logic             goClr,
   input  wire logic             treClr,
   input  wire logic             setNem,
   input  wire logic             setPge,
   output rhPkg::rhCs2T          cs2,
   output logic                  errSum
);

   import rhPkg::*;

   logic       upe;
   logic       nem;
   logic       pge;
   logic       mxf;
   logic       pat;
   logic       bai;
   logic [2:0] unit;
   logic       wrLo;
   logic       wrHi;
   logic       ctlClr;
   logic       errClr;
   rhCs2T      wd;

   // Write decode, valid already gated by ready
   assign wd   = regWrite.data.cs2;
   assign wrLo = regWrite.valid & (regWrite.regSel == regCs2) & regWrite.loByte;
   assign wrHi = regWrite.valid & (regWrite.regSel == regCs2) & regWrite.hiByte;

   // Controller clear is the write itself
   assign ctlClr = wrLo & wd.clr;
   // Clear group for the transfer errors
   assign errClr = ctlClr | treClr | goClr;

   //////////////////////////////////////////////////
   // Error flags, clear wins over set
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         upe <= 1'b0;
         nem <= 1'b0;
         pge <= 1'b0;
         mxf <= 1'b0;
      end
      else
      begin
         // Software-settable error bits, hi byte
         if (errClr)
         begin
            upe <= 1'b0;
            mxf <= 1'b0;
         end
         else if (wrHi)
         begin
            upe <= wd.upe;
            mxf <= wd.mxf;
         end
         // NEM from the engine
         if (errClr)
            nem <= 1'b0;
         else if (setNem)
            nem <= 1'b1;
         // PGE survives goClr, which is the point of it
         if (ctlClr | treClr)
            pge <= 1'b0;
         else if (setPge)
            pge <= 1'b1;
      end
   end

   //////////////////////////////////////////////////
   // Unit control, lo byte
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst | ctlClr)
      begin
         pat  <= 1'b0;
         bai  <= 1'b0;
         unit <= '0;
      end
      else if (wrLo)
      begin
         pat  <= wd.pat;
         bai  <= wd.bai;
         unit <= wd.unit;
      end
   end

   assign errSum = upe | nem | pge | mxf;

   // Read view, unmodelled flags tied low
   always_comb
   begin
      cs2      = '0;
      cs2.upe  = upe;
      cs2.nem  = nem;
      cs2.pge  = pge;
      cs2.mxf  = mxf;
      cs2.clr  = ctlClr;
      cs2.pat  = pat;
      cs2.bai  = bai;
      cs2.unit = unit;
   end

endmodule

`default_nettype wire

/* hw/xferEngine.sv */
// Transfer sequencer with WC and BA registers and non-existent memory detect
`timescale 1ns/1ps
`default_nettype none

module xferEngine
#(
   parameter logic [15:0] memTop = 16'h0400
)
(
   input  wire logic             clk,
   input  wire logic             rst,
   input  wire axiPkg::regWriteT regWrite,
   input  wire logic             startXfer,
   input  wire logic             bai,
   output logic [15:0]           wc,
   output logic [15:0]           ba,
   output logic                  busy,
   output logic                  done,
   output logic                  setNem
);

   import rhPkg::*;

   logic wcWrite;
   logic baWrite;
   logic atLimit;
   logic wcZero;
   logic step;

   // Byte-lane merge for the two software registers
   function automatic logic [15:0] laneMerge(input logic [15:0] cur,
                                             input logic [15:0] nxt,
                                             input logic        lo,
                                             input logic        hi);
      logic [15:0] res;
      res       = cur;
      if (lo)
         res[7:0]  = nxt[7:0];
      if (hi)
         res[15:8] = nxt[15:8];
      return res;
   endfunction

   // Software access only while idle
   assign wcWrite = regWrite.valid & (regWrite.regSel == regWc) & ~busy;
   assign baWrite = regWrite.valid & (regWrite.regSel == regBa) & ~busy;

   // Word address compared against the first missing word
   assign atLimit = {1'b0, ba[15:1]} >= memTop;
   assign wcZero  = (wc == 16'h0000);

   // Stop on empty count or on the limit, checked before each step
   assign done   = busy & (wcZero | atLimit);
   assign setNem = busy & ~wcZero & atLimit;
   assign step   = busy & ~wcZero & ~atLimit;

   //////////////////////////////////////////////////
   // Sequencer
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
         busy <= 1'b0;
      else if (startXfer)
         busy <= 1'b1;
      else if (done)
         busy <= 1'b0;
   end

   //////////////////////////////////////////////////
   // Word count and bus address
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wc <= '0;
         ba <= '0;
      end
      else if (step)
      begin
         // One word per cycle
         wc <= wc - 16'd1;
         if (!bai)
            ba <= ba + 16'd2;
      end
      else
      begin
         if (wcWrite)
            wc <= laneMerge(wc, regWrite.data.raw, regWrite.loByte, regWrite.hiByte);
         if (baWrite)
            ba <= laneMerge(ba, regWrite.data.raw, regWrite.loByte, regWrite.hiByte);
      end
   end

endmodule

`default_nettype wire

/* hw/rhTop.sv */
// Controller top level: AXI port, CS1 and CS2 registers, transfer engine
`timescale 1ns/1ps
`default_nettype none

module rhTop
#(
   parameter logic [15:0] memTop = 16'h0800
)
(
   input  wire logic           clk,
   input  wire logic           rst,
   input  wire axiPkg::axiReqT req,
   output axiPkg::axiRspT      rsp,
   output logic                irq
);

   import rhPkg::*;
   import axiPkg::*;

   regWriteT    regWrite;
   regWriteT    cs2Write;
   rhCs1T       cs1;
   rhCs2T       cs2;
   logic [15:0] wc;
   logic [15:0] ba;
   logic        startXfer;
   logic        goClr;
   logic        treClr;
   logic        setPge;
   logic        setNem;
   logic        errSum;
   logic        busy;
   logic        done;

   // CS2 writable only while ready, keeps bai steady in a transfer
   always_comb
   begin
      cs2Write       = regWrite;
      cs2Write.valid = regWrite.valid & cs1.rdy;
   end

   //////////////////////////////////////////////////
   // Host side
   //////////////////////////////////////////////////

   axiRegPort i_axiRegPort
   (
      .clk      (clk),
      .rst      (rst),
      .req      (req),
      .rsp      (rsp),
      .regWrite (regWrite),
      .cs1      (cs1),
      .cs2      (cs2),
      .wc       (wc),
      .ba       (ba)
   );

   //////////////////////////////////////////////////
   // Registers
   //////////////////////////////////////////////////

   rhCs1 i_rhCs1
   (
      .clk       (clk),
      .rst       (rst),
      .regWrite  (regWrite),
      .busy      (busy),
      .done      (done),
      .errSum    (errSum),
      .cs1       (cs1),
      .startXfer (startXfer),
      .goClr     (goClr),
      .treClr    (treClr),
      .setPge    (setPge),
      .irq       (irq)
   );

   rhCs2 i_rhCs2
   (
      .clk      (clk),
      .rst      (rst),
      .regWrite (cs2Write),
      .goClr    (goClr),
      .treClr   (treClr),
      .setNem   (setNem),
      .setPge   (setPge),
      .cs2      (cs2),
      .errSum   (errSum)
   );

   // Transfer engine
   xferEngine #(.memTop(memTop)) i_xferEngine
   (
      .clk       (clk),
      .rst       (rst),
      .regWrite  (regWrite),
      .startXfer (startXfer),
      .bai       (cs2.bai),
      .wc        (wc),
      .ba        (ba),
      .busy      (busy),
      .done      (done),
      .setNem    (setNem)
   );

endmodule

`default_nettype wire

/* tests/rh_checker.sv */
// Bound assertions: AXI4-Lite response holds, interrupt pulse width, ready against busy
`timescale 1ns/1ps
`default_nettype none

module rhChecker
(
   input wire logic           clk,
   input wire logic           rst,
   input wire axiPkg::axiReqT req,
   input wire axiPkg::axiRspT rsp,
   input wire logic           irq,
   input wire logic           rdy,
   input wire logic           busy
);

   // Write response stays up until the host takes it
   bHold: assert property (@(posedge clk) disable iff (rst)
      rsp.bvalid && !req.bready |=> rsp.bvalid)
      else $error("bvalid dropped before bready");

   // Same rule on the read data channel
   rHold: assert property (@(posedge clk) disable iff (rst)
      rsp.rvalid && !req.rready |=> rsp.rvalid)
      else $error("rvalid dropped before rready");

   // Interrupt is a single-cycle pulse
   irqPulse: assert property (@(posedge clk) disable iff (rst) irq |=> !irq)
      else $error("irq held longer than one cycle");

   // Ready comes back only once the engine has stopped
   rdyRise: assert property (@(posedge clk) disable iff (rst) $rose(rdy) |-> !busy)
      else $error("rdy rose while the engine was busy");

   rdyBusy: assert property (@(posedge clk) disable iff (rst) !(rdy && busy))
      else $error("rdy and busy high together");

endmodule

`default_nettype wire

/* tests/rhTb.sv */
// Testbench: clock, reset, AXI4-Lite tasks, LCG, transfer model, compare tasks, checker bind
`timescale 1ns/1ps
`default_nettype none

module rhTb;

   import rhPkg::*;
   import axiPkg::*;

   // Smaller memory than the default so crossings stay short
   localparam logic [15:0] memLimit = 16'h0100;
   localparam logic [31:0] lowSpan  = 32'(memLimit) - 32'd48;

   typedef enum logic [1:0] {chkNone, chkCs1, chkCs2, chkWord} chkKindT;

   // End state of one transfer
   typedef struct packed {
      logic [15:0] wc;
      logic [15:0] ba;
      logic        nem;
   } xferT;

   logic        clk;
   logic        rst;
   axiReqT      req;
   axiRspT      rsp;
   logic        irq;
   logic [31:0] seed;
   logic [15:0] irqCount;
   rhCs1T       mCs1;
   rhCs2T       mCs2;
   logic [15:0] mWc;
   logic [15:0] mBa;
   // Expected read results in issue order
   chkKindT     kindQ[$];
   logic [15:0] expQ[$];
   string       nameQ[$];

   rhTop #(.memTop(memLimit)) i_rhTop
   (
      .clk (clk),
      .rst (rst),
      .req (req),
      .rsp (rsp),
      .irq (irq)
   );

   bind rhTop rhChecker i_rhChecker
   (
      .clk  (clk),
      .rst  (rst),
      .req  (req),
      .rsp  (rsp),
      .irq  (irq),
      .rdy  (cs1.rdy),
      .busy (busy)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   //////////////////////////////////////////////////
   // Helpers and compare tasks
   //////////////////////////////////////////////////

   task automatic abortRun(input string why);
      $display("%s", why);
      $display("Simulation FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   // LCG with the usual 32-bit constants
   function automatic logic [31:0] nextRand();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   task automatic checkCs1(input string name, input rhCs1T exp, input rhCs1T got);
      if (got !== exp)
         abortRun($sformatf("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, got));
   endtask

   task automatic checkCs2(input string name, input rhCs2T exp, input rhCs2T got);
      if (got !== exp)
         abortRun($sformatf("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, got));
   endtask

   task automatic checkWord(input string name, input logic [15:0] exp, input logic [15:0] got);
      if (got !== exp)
         abortRun($sformatf("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, got));
   endtask

   task automatic checkResp(input string name, input logic [1:0] exp, input logic [1:0] got);
      if (got !== exp)
         abortRun($sformatf("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, got));
   endtask

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////

   // Step one word at a time and stop on empty count or at the memory limit
   function automatic xferT rhModel(input logic [15:0] wcIn, input logic [15:0] baIn,
                                    input logic baiIn);
      xferT r;
      r.wc = wcIn;
      r.ba = baIn;
      while (r.wc != 16'd0 && (r.ba >> 1) < memLimit)
      begin
         r.wc = r.wc - 16'd1;
         if (!baiIn)
            r.ba = r.ba + 16'd2;
      end
      // Words left over means the limit stopped it
      r.nem = (r.wc != 16'd0);
      return r;
   endfunction

   // CS1 as read while idle with sc and tre as the error summary
   function automatic rhCs1T predictCs1();
      rhCs1T c;
      c      = '0;
      c.sc   = mCs2.upe | mCs2.nem | mCs2.pge | mCs2.mxf;
      c.tre  = c.sc;
      c.rdy  = mCs1.rdy;
      c.ie   = mCs1.ie;
      c.func = mCs1.func;
      return c;
   endfunction

   //////////////////////////////////////////////////
   // Bus tasks called 5 ns after a rising edge
   //////////////////////////////////////////////////

   task automatic writeReg(input logic [3:0] addr, input logic [15:0] data,
                           input logic [3:0] strb);
      int i;
      req.awaddr  = addr;
      req.wdata   = {16'h0000, data};
      req.wstrb   = strb;
      req.awvalid = 1'b1;
      req.wvalid  = 1'b1;
      for (i = 0; i < 20; i++)
      begin
         @(negedge clk);
         if (rsp.awready)
            break;
      end
      if (!rsp.awready)
         abortRun("Timeout waiting for awready on a register write");
      if (!rsp.wready)
         abortRun("wready did not rise together with awready");
      @(posedge clk);
      #5;
      req.awvalid = 1'b0;
      req.wvalid  = 1'b0;
      req.bready  = 1'b1;
      for (i = 0; i < 20; i++)
      begin
         @(negedge clk);
         if (rsp.bvalid)
            break;
      end
      if (!rsp.bvalid)
         abortRun("Timeout waiting for the write response");
      checkResp("bresp", 2'b00, rsp.bresp);
      @(posedge clk);
      #5;
      req.bready = 1'b0;
   endtask

   task automatic readReg(input logic [3:0] addr, input chkKindT kind,
                          input logic [15:0] exp, input string name,
                          output logic [15:0] data);
      int i;
      kindQ.push_back(kind);
      expQ.push_back(exp);
      nameQ.push_back(name);
      req.araddr  = addr;
      req.arvalid = 1'b1;
      for (i = 0; i < 20; i++)
      begin
         @(negedge clk);
         if (rsp.arready)
            break;
      end
      if (!rsp.arready)
         abortRun("Timeout waiting for arready on a register read");
      @(posedge clk);
      #5;
      req.arvalid = 1'b0;
      req.rready  = 1'b1;
      for (i = 0; i < 20; i++)
      begin
         @(negedge clk);
         if (rsp.rvalid)
            break;
      end
      if (!rsp.rvalid)
         abortRun("Timeout waiting for read data");
      checkResp("rresp", 2'b00, rsp.rresp);
      // Registers are 16 bits, zero-extended on the bus
      checkWord("rdata[31:16]", 16'h0000, rsp.rdata[31:16]);
      data = rsp.rdata[15:0];
      @(posedge clk);
      #5;
      req.rready = 1'b0;
   endtask

   // Read back all four registers against the model
   task automatic verifyRegs();
      logic [15:0] d;
      readReg(offCs1, chkCs1, predictCs1(), "CS1", d);
      readReg(offCs2, chkCs2, mCs2, "CS2", d);
      readReg(offWc, chkWord, mWc, "WC", d);
      readReg(offBa, chkWord, mBa, "BA", d);
   endtask

   // Set up, GO, poll ready, then compare
   task automatic runXfer(input logic [15:0] wcV, input logic [15:0] baV, input logic baiV,
                          input logic ieV, input logic [4:0] fn, input logic goAgain);
      rhCs2T       c2;
      rhCs1T       c1;
      xferT        res;
      logic [15:0] irqStart;
      logic [15:0] d;
      int          polls;
      c2      = '0;
      c2.bai  = baiV;
      c2.unit = 3'(nextRand() >> 8);
      writeReg(offCs2, c2, 4'b0001);
      mCs2.pat  = 1'b0;
      mCs2.bai  = baiV;
      mCs2.unit = c2.unit;
      writeReg(offWc, wcV, 4'b0011);
      writeReg(offBa, baV, 4'b0011);
      mWc = wcV;
      mBa = baV;
      c1      = '0;
      c1.go   = 1'b1;
      c1.ie   = ieV;
      c1.func = fn;
      irqStart = irqCount;
      writeReg(offCs1, c1, 4'b0001);
      // Start clears the transfer errors but not pge
      mCs1.ie   = ieV;
      mCs1.func = fn;
      mCs2.upe  = 1'b0;
      mCs2.nem  = 1'b0;
      mCs2.mxf  = 1'b0;
      // Second GO lands mid-transfer
      if (goAgain)
      begin
         writeReg(offCs1, c1, 4'b0001);
         mCs2.pge = 1'b1;
      end
      c1 = '0;
      for (polls = 0; polls < 400; polls++)
      begin
         readReg(offCs1, chkNone, 16'h0000, "CS1", d);
         c1 = rhCs1T'(d);
         if (c1.rdy)
            break;
      end
      if (!c1.rdy)
         abortRun("Timeout waiting for ready at the end of a transfer");
      res = rhModel(wcV, baV, baiV);
      mWc = res.wc;
      mBa = res.ba;
      if (res.nem)
         mCs2.nem = 1'b1;
      verifyRegs();
      checkWord("irqPulses", ieV ? 16'd1 : 16'd0, irqCount - irqStart);
   endtask

   //////////////////////////////////////////////////
   // Monitors
   //////////////////////////////////////////////////

   always @(negedge clk)
   begin
      if (rst)
         irqCount = 16'd0;
      else if (irq)
         irqCount = irqCount + 16'd1;
   end

   // Each completed read against the next expectation
   always @(negedge clk)
   begin : compareReads
      chkKindT     kind;
      logic [15:0] exp;
      string       name;
      if (rsp.rvalid && req.rready)
      begin
         if (kindQ.size() == 0)
            abortRun("Read data returned with no read outstanding");
         kind = kindQ.pop_front();
         exp  = expQ.pop_front();
         name = nameQ.pop_front();
         case (kind)
            chkCs1:  checkCs1(name, rhCs1T'(exp), rhCs1T'(rsp.rdata[15:0]));
            chkCs2:  checkCs2(name, rhCs2T'(exp), rhCs2T'(rsp.rdata[15:0]));
            chkWord: checkWord(name, exp, rsp.rdata[15:0]);
            default: ;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   initial
   begin : mainFlow
      rhCs2T       w2;
      rhCs1T       w1;
      logic [31:0] r;
      logic [31:0] k;
      int          n;
      rst  = 1'b1;
      req  = '0;
      seed = 32'h4094_4681;
      repeat (4) @(posedge clk);
      #5;
      rst = 1'b0;

      // Reset values
      mCs1     = '0;
      mCs1.rdy = 1'b1;
      mCs2     = '0;
      mWc      = 16'h0000;
      mBa      = 16'h0000;
      verifyRegs();

      // CS2 lo byte, unit control, hi byte data must not land
      r       = nextRand();
      w2      = '0;
      w2.unit = r[10:8];
      w2.bai  = 1'b1;
      w2.pat  = 1'b1;
      w2.upe  = 1'b1;
      w2.mxf  = 1'b1;
      writeReg(offCs2, w2, 4'b0001);
      mCs2.unit = w2.unit;
      mCs2.bai  = 1'b1;
      mCs2.pat  = 1'b1;
      verifyRegs();
      // Hi byte, software error bits
      w2     = '0;
      w2.upe = 1'b1;
      w2.mxf = 1'b1;
      writeReg(offCs2, w2, 4'b0010);
      mCs2.upe = 1'b1;
      mCs2.mxf = 1'b1;
      verifyRegs();
      // Controller clear wipes it all, even the lo byte fields written with it
      w2      = '0;
      w2.clr  = 1'b1;
      w2.pat  = 1'b1;
      w2.bai  = 1'b1;
      w2.unit = 3'b111;
      writeReg(offCs2, w2, 4'b0001);
      mCs2 = '0;
      verifyRegs();

      // Random transfers inside memory
      for (n = 0; n < 6; n++)
      begin
         r = nextRand();
         runXfer(16'(r % 32'd32) + 16'd1, 16'((nextRand() % lowSpan) << 1), r[8], r[9],
                 r[10] ? funcRead : funcWrite, 1'b0);
      end

      // Crossing the limit sets nem
      k = 32'd1 + (nextRand() % 32'd8);
      runXfer(16'(k + 32'd1 + (nextRand() % 32'd8)), 16'((32'(memLimit) - k) << 1),
              1'b0, 1'b1, funcWrite, 1'b0);

      // GO while busy gives pge
      runXfer(16'd40, 16'h0000, 1'b0, 1'b0, funcRead, 1'b1);
      // pge survives and nem sets again
      runXfer(16'd12, 16'((32'(memLimit) - 32'd4) << 1), 1'b0, 1'b1, funcRead, 1'b0);
      // Next start clears nem only
      runXfer(16'd5, 16'h0010, 1'b0, 1'b0, funcWrite, 1'b0);
      // tre write on the hi byte clears pge
      w1     = '0;
      w1.tre = 1'b1;
      writeReg(offCs1, w1, 4'b0010);
      mCs2.pge = 1'b0;
      mCs2.nem = 1'b0;
      mCs2.upe = 1'b0;
      mCs2.mxf = 1'b0;
      verifyRegs();

      if (kindQ.size() != 0)
         abortRun("Read checks still pending at the end of the run");
      else
      begin
         $display("Simulation PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* filelist.f */
hw/rhPkg.sv
hw/axiPkg.sv
hw/axiRegPort.sv
hw/rhCs1.sv
hw/rhCs2.sv
hw/xferEngine.sv
hw/rhTop.sv
tests/rh_checker.sv
tests/rhTb.sv

/* run.sh */
#!/bin/sh
# Build and run the controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module rhTb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/VrhTb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi
exit 0
